//--- Bender.yml
package:
  name: tsc_cpu

sources:
  - verilog/tsc_pkg.sv
  - verilog/fetch_stage.sv
  - verilog/register_file.sv
  - verilog/decode_stage.sv
  - verilog/execute_stage.sv
  - verilog/memory_stage.sv
  - verilog/writeback_stage.sv
  - verilog/tsc_cpu.sv
  - target: test
    files:
      - test/tsc_cpu_tb.sv

//--- test/tsc_cpu_tb.sv
`timescale 1ns/1ns
`default_nettype none

module tsc_cpu_tb;

	localparam int HALT_TIMEOUT = 1000;

	logic clk;
	logic reset_n;
	logic i_read;
	tsc_pkg::word_t i_address;
	tsc_pkg::word_t i_data;
	logic d_read;
	logic d_write;
	tsc_pkg::word_t d_address;
	tsc_pkg::word_t d_wdata;
	tsc_pkg::word_t d_rdata;
	tsc_pkg::word_t output_port;
	logic out_strobe;
	tsc_pkg::word_t num_inst;
	logic is_halted;

	tsc_pkg::word_t prog [256];
	tsc_pkg::word_t dmem [256];
	tsc_pkg::word_t exp_mem [256];
	tsc_pkg::word_t exp_out [256];
	int exp_out_n;
	int seen_n;
	int prog_len;
	int errors;
	int timeouts;
	string test_name;
	logic [31:0] rng;

	tsc_cpu #(.RESET_PC(16'h0000)) dut (
		.clk(clk), .reset_n(reset_n),
		.i_read_o(i_read), .i_address_o(i_address), .i_data_i(i_data),
		.d_read_o(d_read), .d_write_o(d_write), .d_address_o(d_address),
		.d_wdata_o(d_wdata), .d_rdata_i(d_rdata),
		.output_port_o(output_port), .out_strobe_o(out_strobe),
		.num_inst_o(num_inst), .is_halted_o(is_halted)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// both memories answer in the same cycle
	assign i_data = prog[i_address[7:0]];
	assign d_rdata = dmem[d_address[7:0]];

	function automatic tsc_pkg::word_t mem_fill(input int a);
		return {a[7:0] ^ 8'hc3, ~a[7:0]};
	endfunction

	// data memory gets its fill pattern back on every reset cycle
	always @(posedge clk) begin
		if (!reset_n) begin
			for (int a = 0; a < 256; a++)
				dmem[a] <= mem_fill(a);
		end else if (d_write) begin
			dmem[d_address[7:0]] <= d_wdata;
		end
	end

	// compares every word written to the output port
	always @(negedge clk) begin
		if (!reset_n) begin
			seen_n <= 0;
		end else if (out_strobe) begin
			if (seen_n < exp_out_n)
				check_value(test_name, $sformatf("output %0d", seen_n),
					exp_out[seen_n], output_port);
			seen_n <= seen_n + 1;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic int next_random(input int n);
		rng = xorshift32(rng);
		return int'(rng % n);
	endfunction

	function automatic tsc_pkg::word_t enc_i(input int op, input int rs, input int rt,
		input int imm);
		return {op[3:0], rs[1:0], rt[1:0], imm[7:0]};
	endfunction

	function automatic tsc_pkg::word_t enc_r(input int rs, input int rt, input int rd,
		input int fn);
		return {tsc_pkg::OP_RTYPE, rs[1:0], rt[1:0], rd[1:0], fn[5:0]};
	endfunction

	function automatic tsc_pkg::word_t enc_jmp(input int target);
		return {tsc_pkg::OP_JMP, target[11:0]};
	endfunction

	// instruction-level model of the ISA
	function automatic int tsc_reference();
		tsc_pkg::word_t regs [4];
		tsc_pkg::word_t pc;
		tsc_pkg::word_t next_pc;
		tsc_pkg::word_t ins;
		tsc_pkg::word_t sext;
		tsc_pkg::word_t addr;
		logic [1:0] rs;
		logic [1:0] rt;
		logic [1:0] rd;
		int retired;
		int steps;
		logic halted;
		for (int i = 0; i < 4; i++)
			regs[i] = '0;
		for (int a = 0; a < 256; a++)
			exp_mem[a] = mem_fill(a);
		exp_out_n = 0;
		pc = '0;
		retired = 0;
		steps = 0;
		halted = 1'b0;
		while (!halted && steps < 4096) begin
			ins = prog[pc[7:0]];
			rs = ins[11:10];
			rt = ins[9:8];
			rd = ins[7:6];
			sext = {{8{ins[7]}}, ins[7:0]};
			addr = regs[rs] + sext;
			next_pc = pc + 16'd1;
			retired++;
			case (ins[15:12])
				tsc_pkg::OP_ADI: regs[rt] = regs[rs] + sext;
				tsc_pkg::OP_ORI: regs[rt] = regs[rs] | {8'h00, ins[7:0]};
				tsc_pkg::OP_LHI: regs[rt] = {ins[7:0], 8'h00};
				tsc_pkg::OP_LWD: regs[rt] = exp_mem[addr[7:0]];
				tsc_pkg::OP_SWD: exp_mem[addr[7:0]] = regs[rt];
				tsc_pkg::OP_JMP: next_pc = {pc[15:12], ins[11:0]};
				tsc_pkg::OP_RTYPE: begin
					case (ins[5:0])
						tsc_pkg::FN_ADD: regs[rd] = regs[rs] + regs[rt];
						tsc_pkg::FN_SUB: regs[rd] = regs[rs] - regs[rt];
						tsc_pkg::FN_AND: regs[rd] = regs[rs] & regs[rt];
						tsc_pkg::FN_ORR: regs[rd] = regs[rs] | regs[rt];
						tsc_pkg::FN_NOT: regs[rd] = ~regs[rs];
						tsc_pkg::FN_TCP: regs[rd] = 16'd0 - regs[rs];
						tsc_pkg::FN_SHL: regs[rd] = regs[rs] << 1;
						tsc_pkg::FN_SHR: regs[rd] = $signed(regs[rs]) >>> 1;
						tsc_pkg::FN_WWD: begin
							exp_out[exp_out_n] = regs[rs];
							exp_out_n++;
						end
						tsc_pkg::FN_HLT: halted = 1'b1;
						default: retired--;
					endcase
				end
				// dropped opcodes are bubbles
				default: retired--;
			endcase
			pc = next_pc;
			steps++;
		end
		return retired;
	endfunction

	task automatic check_value(input string test, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("Mismatch %s %s: expected %h, actual %h", test, what, expected, actual);
		end
	endtask

	task automatic finish_run();
		$display("closing: %0d mismatches, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	endtask

	task automatic clear_program();
		// unused words hold stores that show up if run past the halt
		for (int a = 0; a < 256; a++)
			prog[a] = {tsc_pkg::OP_SWD, 4'h0, a[7:0]};
		prog_len = 0;
	endtask

	task automatic emit(input tsc_pkg::word_t instr);
		prog[prog_len] = instr;
		prog_len++;
	endtask

	task automatic build_dependent_program();
		clear_program();
		emit(enc_i(tsc_pkg::OP_LHI, 0, 1, 8'h12));
		emit(enc_i(tsc_pkg::OP_ORI, 1, 1, 8'h34));
		emit(enc_i(tsc_pkg::OP_ADI, 1, 2, 8'hff));
		emit(enc_r(1, 2, 3, tsc_pkg::FN_ADD));
		emit(enc_r(3, 1, 0, tsc_pkg::FN_SUB));
		emit(enc_r(0, 0, 0, tsc_pkg::FN_WWD));
		emit(enc_r(3, 0, 0, tsc_pkg::FN_WWD));
		emit(enc_r(3, 0, 1, tsc_pkg::FN_SHL));
		emit(enc_r(1, 0, 2, tsc_pkg::FN_TCP));
		emit(enc_r(2, 3, 0, tsc_pkg::FN_AND));
		emit(enc_r(0, 0, 0, tsc_pkg::FN_WWD));
		emit(enc_r(2, 0, 3, tsc_pkg::FN_NOT));
		emit(enc_r(3, 0, 1, tsc_pkg::FN_SHR));
		emit(enc_r(1, 3, 2, tsc_pkg::FN_ORR));
		emit(enc_r(2, 0, 0, tsc_pkg::FN_WWD));
		emit(enc_r(1, 0, 0, tsc_pkg::FN_WWD));
		emit(enc_r(0, 0, 0, tsc_pkg::FN_HLT));
	endtask

	task automatic build_load_store_program();
		clear_program();
		emit(enc_i(tsc_pkg::OP_LHI, 0, 0, 0));
		emit(enc_i(tsc_pkg::OP_ADI, 0, 1, 8'h20));
		emit(enc_i(tsc_pkg::OP_LWD, 1, 2, 3));
		emit(enc_i(tsc_pkg::OP_ADI, 2, 2, 1));
		emit(enc_i(tsc_pkg::OP_SWD, 1, 2, 5));
		emit(enc_i(tsc_pkg::OP_LWD, 1, 3, 5));
		emit(enc_r(3, 0, 0, tsc_pkg::FN_WWD));
		emit(enc_i(tsc_pkg::OP_LWD, 1, 0, 8'h10));
		// store data straight from a load
		emit(enc_i(tsc_pkg::OP_SWD, 1, 0, 0));
		emit(enc_i(tsc_pkg::OP_LWD, 1, 1, 0));
		emit(enc_r(1, 1, 2, tsc_pkg::FN_ADD));
		emit(enc_r(2, 0, 0, tsc_pkg::FN_WWD));
		emit(enc_i(tsc_pkg::OP_LHI, 0, 3, 0));
		emit(enc_i(tsc_pkg::OP_SWD, 3, 2, 8'h2a));
		emit(enc_i(tsc_pkg::OP_LWD, 3, 0, 8'h2a));
		emit(enc_i(tsc_pkg::OP_SWD, 3, 0, 8'h2b));
		emit(enc_r(1, 0, 0, tsc_pkg::FN_WWD));
		emit(enc_r(0, 0, 0, tsc_pkg::FN_HLT));
	endtask

	task automatic build_jump_program();
		clear_program();
		emit(enc_i(tsc_pkg::OP_ADI, 0, 1, 1));
		emit(enc_jmp(3));
		emit(enc_r(1, 0, 0, tsc_pkg::FN_WWD));
		emit(enc_r(1, 0, 0, tsc_pkg::FN_WWD));
		emit(enc_i(tsc_pkg::OP_ADI, 1, 1, 2));
		emit(enc_jmp(8));
		emit(enc_i(tsc_pkg::OP_ADI, 1, 1, 8'h40));
		emit(enc_r(1, 0, 0, tsc_pkg::FN_WWD));
		emit(enc_r(1, 0, 0, tsc_pkg::FN_WWD));
		emit(enc_jmp(11));
		emit(enc_r(0, 0, 0, tsc_pkg::FN_WWD));
		emit(enc_r(0, 0, 0, tsc_pkg::FN_HLT));
	endtask

	// r0 stays zero, so it is the base of every load and store
	task automatic build_random_program();
		int n;
		int kind;
		int d;
		int s;
		int t;
		clear_program();
		n = 12 + next_random(29);
		while (prog_len < n - 1) begin
			kind = next_random(16);
			d = 1 + next_random(3);
			s = next_random(4);
			t = next_random(4);
			if (kind < 5)
				emit(enc_r(s, t, d, next_random(8)));
			else if (kind == 5)
				emit(enc_i(tsc_pkg::OP_ADI, s, d, next_random(256)));
			else if (kind == 6)
				emit(enc_i(tsc_pkg::OP_ORI, s, d, next_random(256)));
			else if (kind == 7)
				emit(enc_i(tsc_pkg::OP_LHI, 0, d, next_random(256)));
			else if (kind < 10)
				emit(enc_i(tsc_pkg::OP_LWD, 0, d, 32'h20 + next_random(16)));
			else if (kind < 12)
				emit(enc_i(tsc_pkg::OP_SWD, 0, t, 32'h20 + next_random(16)));
			else if (kind < 14 || prog_len + 3 > n - 1)
				emit(enc_r(s, 0, 0, tsc_pkg::FN_WWD));
			else
				emit(enc_jmp(prog_len + 2 + next_random(2)));
		end
		emit(enc_r(0, 0, 0, tsc_pkg::FN_HLT));
	endtask

	task automatic check_quiet(input string test);
		check_value(test, "out_strobe", 0, out_strobe);
		check_value(test, "is_halted", 0, is_halted);
		check_value(test, "d_write", 0, d_write);
		check_value(test, "d_read", 0, d_read);
		check_value(test, "num_inst", 0, num_inst);
	endtask

	task automatic run_program(input string name);
		int exp_count;
		int cycles;
		tsc_pkg::word_t halt_count;
		exp_count = tsc_reference();
		test_name = name;
		@(negedge clk);
		reset_n = 1'b0;
		for (int c = 0; c < 10; c++) begin
			@(negedge clk);
			check_quiet("reset");
			check_value("reset", "i_read", 0, i_read);
		end
		reset_n = 1'b1;
		// pipeline is still empty for the first cycles
		for (int c = 0; c < 3; c++) begin
			@(negedge clk);
			check_quiet("reset");
		end
		cycles = 0;
		while (!is_halted && cycles < HALT_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (!is_halted) begin
			$display("timeout: %s did not halt within %0d cycles", name, cycles);
			timeouts++;
		end else begin
			check_value(name, "output count", exp_out_n, seen_n);
			check_value(name, "num_inst", exp_count, num_inst);
			for (int a = 0; a < 256; a++)
				check_value(name, $sformatf("dmem[%02h]", a), exp_mem[a], dmem[a]);
			halt_count = num_inst;
			for (int c = 0; c < 20; c++) begin
				@(negedge clk);
				check_value(name, "halt is_halted", 1, is_halted);
				check_value(name, "halt num_inst", halt_count, num_inst);
				check_value(name, "halt out_strobe", 0, out_strobe);
				check_value(name, "halt d_write", 0, d_write);
			end
		end
	endtask

	initial begin
		reset_n = 1'b0;
		errors = 0;
		timeouts = 0;
		rng = 32'heed;
		clear_program();
		build_dependent_program();
		run_program("dependent_ops");
		build_load_store_program();
		run_program("load_store");
		build_jump_program();
		run_program("jump");
		for (int p = 0; p < 20; p++) begin
			build_random_program();
			run_program($sformatf("random_%0d", p));
		end
		finish_run();
	end

endmodule

`default_nettype wire

//--- tsc_cpu.f
verilog/tsc_pkg.sv
verilog/fetch_stage.sv
verilog/register_file.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/writeback_stage.sv
verilog/tsc_cpu.sv
test/tsc_cpu_tb.sv

//--- verilog/decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
	input wire clk,
	input wire reset_n,
	input wire tsc_pkg::word_t instr_i,
	input wire tsc_pkg::word_t pc_i,
	input wire valid_i,
	input wire tsc_pkg::word_t rs_data_i,
	input wire tsc_pkg::word_t rt_data_i,
	output tsc_pkg::reg_addr_t rs_o,
	output tsc_pkg::reg_addr_t rt_o,
	output logic stall_o,
	output logic redirect_o,
	output tsc_pkg::word_t redirect_pc_o,
	output logic halt_o,
	output tsc_pkg::word_t a_o,
	output tsc_pkg::word_t b_o,
	output tsc_pkg::reg_addr_t src_a_o,
	output tsc_pkg::reg_addr_t src_b_o,
	output tsc_pkg::reg_addr_t dest_o,
	output tsc_pkg::word_t imm_o,
	output tsc_pkg::alu_op_t alu_op_o,
	output logic use_imm_o,
	output logic mem_read_o,
	output logic mem_write_o,
	output logic reg_write_o,
	output logic wwd_o,
	output logic halt_flag_o,
	output logic valid_o
);

	tsc_pkg::opcode_t opcode;
	tsc_pkg::funct_t funct;
	tsc_pkg::reg_addr_t rd;
	tsc_pkg::reg_addr_t dest;
	tsc_pkg::word_t imm;
	tsc_pkg::alu_op_t alu_op;
	logic known, uses_rs, uses_rt, use_imm;
	logic mem_rd, mem_wr, reg_wr, wwd, is_hlt, is_jmp;
	logic halt_seen, load_use, issue;

	assign opcode = instr_i[15:12];
	assign funct = instr_i[5:0];
	assign rs_o = instr_i[11:10];
	assign rt_o = instr_i[9:8];
	assign rd = instr_i[7:6];
	assign redirect_pc_o = {pc_i[15:12], instr_i[11:0]};

	always_comb begin
		known = 1'b0;
		uses_rs = 1'b0;
		uses_rt = 1'b0;
		dest = rt_o;
		imm = {{8{instr_i[7]}}, instr_i[7:0]};
		alu_op = tsc_pkg::ALU_ADD;
		use_imm = 1'b1;
		mem_rd = 1'b0;
		mem_wr = 1'b0;
		reg_wr = 1'b0;
		wwd = 1'b0;
		is_hlt = 1'b0;
		is_jmp = 1'b0;
		case (opcode)
			tsc_pkg::OP_ADI: begin
				known = 1'b1;
				uses_rs = 1'b1;
				reg_wr = 1'b1;
			end
			tsc_pkg::OP_ORI: begin
				known = 1'b1;
				uses_rs = 1'b1;
				reg_wr = 1'b1;
				imm = {8'h00, instr_i[7:0]};
				alu_op = tsc_pkg::ALU_OR;
			end
			tsc_pkg::OP_LHI: begin
				known = 1'b1;
				reg_wr = 1'b1;
				imm = {instr_i[7:0], 8'h00};
				alu_op = tsc_pkg::ALU_PASS_B;
			end
			tsc_pkg::OP_LWD: begin
				known = 1'b1;
				uses_rs = 1'b1;
				mem_rd = 1'b1;
				reg_wr = 1'b1;
			end
			tsc_pkg::OP_SWD: begin
				known = 1'b1;
				uses_rs = 1'b1;
				uses_rt = 1'b1;
				mem_wr = 1'b1;
			end
			tsc_pkg::OP_JMP: begin
				known = 1'b1;
				is_jmp = 1'b1;
			end
			tsc_pkg::OP_RTYPE: begin
				use_imm = 1'b0;
				dest = rd;
				if (funct <= tsc_pkg::FN_SHR) begin
					known = 1'b1;
					uses_rs = 1'b1;
					// not, tcp and the shifts are unary
					uses_rt = funct <= tsc_pkg::FN_ORR;
					reg_wr = 1'b1;
					alu_op = tsc_pkg::alu_op_t'({1'b0, funct[2:0]});
				end else if (funct == tsc_pkg::FN_WWD) begin
					known = 1'b1;
					uses_rs = 1'b1;
					wwd = 1'b1;
				end else if (funct == tsc_pkg::FN_HLT) begin
					known = 1'b1;
					is_hlt = 1'b1;
				end
			end
			default: ;
		endcase
	end

	// load in execute feeding this instruction
	assign load_use = valid_o && mem_read_o &&
		((uses_rs && dest_o == rs_o) || (uses_rt && dest_o == rt_o));
	assign stall_o = valid_i && !halt_seen && load_use;
	assign redirect_o = valid_i && !halt_seen && is_jmp;
	assign halt_o = halt_seen || (valid_i && is_hlt);
	assign issue = valid_i && known && !halt_seen && !load_use;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			halt_seen <= 1'b0;
			mem_read_o <= 1'b0;
			mem_write_o <= 1'b0;
			reg_write_o <= 1'b0;
			wwd_o <= 1'b0;
			halt_flag_o <= 1'b0;
			valid_o <= 1'b0;
		end else begin
			if (issue && is_hlt)
				halt_seen <= 1'b1;
			mem_read_o <= issue && mem_rd;
			mem_write_o <= issue && mem_wr;
			reg_write_o <= issue && reg_wr;
			wwd_o <= issue && wwd;
			halt_flag_o <= issue && is_hlt;
			valid_o <= issue;
		end
	end

	always_ff @(posedge clk) begin
		a_o <= rs_data_i;
		b_o <= rt_data_i;
		src_a_o <= rs_o;
		src_b_o <= rt_o;
		dest_o <= dest;
		imm_o <= imm;
		alu_op_o <= alu_op;
		use_imm_o <= use_imm;
	end

endmodule

`default_nettype wire

//--- verilog/execute_stage.sv
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
	input wire clk,
	input wire reset_n,
	input wire tsc_pkg::word_t a_i,
	input wire tsc_pkg::word_t b_i,
	input wire tsc_pkg::reg_addr_t src_a_i,
	input wire tsc_pkg::reg_addr_t src_b_i,
	input wire tsc_pkg::reg_addr_t dest_i,
	input wire tsc_pkg::word_t imm_i,
	input wire tsc_pkg::alu_op_t alu_op_i,
	input wire use_imm_i,
	input wire mem_read_i,
	input wire mem_write_i,
	input wire reg_write_i,
	input wire wwd_i,
	input wire halt_flag_i,
	input wire valid_i,
	input wire tsc_pkg::reg_addr_t mem_dest_i,
	input wire tsc_pkg::word_t mem_result_i,
	input wire mem_reg_write_i,
	input wire tsc_pkg::reg_addr_t wb_dest_i,
	input wire tsc_pkg::word_t wb_data_i,
	input wire wb_reg_write_i,
	output tsc_pkg::word_t result_o,
	output tsc_pkg::word_t store_data_o,
	output tsc_pkg::reg_addr_t dest_o,
	output logic mem_read_o,
	output logic mem_write_o,
	output logic reg_write_o,
	output logic wwd_o,
	output logic halt_o,
	output logic valid_o
);

	tsc_pkg::fwd_sel_t fwd_a, fwd_b;
	tsc_pkg::word_t op_a, op_b, alu_b, alu_y;
	logic a_used, b_used;

	// memory stage is younger, so it is checked first
	always_comb begin
		fwd_a = tsc_pkg::FWD_REG;
		if (mem_reg_write_i && mem_dest_i == src_a_i)
			fwd_a = tsc_pkg::FWD_MEM;
		else if (wb_reg_write_i && wb_dest_i == src_a_i)
			fwd_a = tsc_pkg::FWD_WB;
		fwd_b = tsc_pkg::FWD_REG;
		if (mem_reg_write_i && mem_dest_i == src_b_i)
			fwd_b = tsc_pkg::FWD_MEM;
		else if (wb_reg_write_i && wb_dest_i == src_b_i)
			fwd_b = tsc_pkg::FWD_WB;
	end

	always_comb begin
		case (fwd_a)
			tsc_pkg::FWD_MEM: op_a = mem_result_i;
			tsc_pkg::FWD_WB: op_a = wb_data_i;
			default: op_a = a_i;
		endcase
		case (fwd_b)
			tsc_pkg::FWD_MEM: op_b = mem_result_i;
			tsc_pkg::FWD_WB: op_b = wb_data_i;
			default: op_b = b_i;
		endcase
	end

	assign alu_b = use_imm_i ? imm_i : op_b;

	// operands that the instruction in execute really reads
	assign a_used = mem_write_i || wwd_i ||
		(reg_write_i && alu_op_i != tsc_pkg::ALU_PASS_B);
	assign b_used = mem_write_i ||
		(!use_imm_i && reg_write_i && alu_op_i <= tsc_pkg::ALU_OR);

	always_comb begin
		case (alu_op_i)
			tsc_pkg::ALU_ADD: alu_y = op_a + alu_b;
			tsc_pkg::ALU_SUB: alu_y = op_a - alu_b;
			tsc_pkg::ALU_AND: alu_y = op_a & alu_b;
			tsc_pkg::ALU_OR: alu_y = op_a | alu_b;
			tsc_pkg::ALU_NOT: alu_y = ~op_a;
			tsc_pkg::ALU_TCP: alu_y = ~op_a + 16'd1;
			tsc_pkg::ALU_SHL: alu_y = {op_a[14:0], 1'b0};
			// arithmetic shift keeps the sign bit
			tsc_pkg::ALU_SHR: alu_y = {op_a[15], op_a[15:1]};
			default: alu_y = alu_b;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			mem_read_o <= 1'b0;
			mem_write_o <= 1'b0;
			reg_write_o <= 1'b0;
			wwd_o <= 1'b0;
			halt_o <= 1'b0;
			valid_o <= 1'b0;
		end else begin
			mem_read_o <= valid_i && mem_read_i;
			mem_write_o <= valid_i && mem_write_i;
			reg_write_o <= valid_i && reg_write_i;
			wwd_o <= valid_i && wwd_i;
			halt_o <= valid_i && halt_flag_i;
			valid_o <= valid_i;
		end
	end

	always_ff @(posedge clk) begin
		// wwd carries its operand down to the output port
		result_o <= wwd_i ? op_a : alu_y;
		store_data_o <= op_b;
		dest_o <= dest_i;
	end

	// a load in the memory stage only holds its address, decode stalls its consumer
	a_fwd_a_ready: assert property (@(posedge clk) disable iff (!reset_n)
		valid_i && a_used && fwd_a == tsc_pkg::FWD_MEM |-> !mem_read_o);
	a_fwd_b_ready: assert property (@(posedge clk) disable iff (!reset_n)
		valid_i && b_used && fwd_b == tsc_pkg::FWD_MEM |-> !mem_read_o);

endmodule

`default_nettype wire

//--- verilog/fetch_stage.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_stage #(
	parameter tsc_pkg::word_t RESET_PC = 16'h0000
) (
	input wire clk,
	input wire reset_n,
	input wire stall_i,
	input wire redirect_i,
	input wire tsc_pkg::word_t redirect_pc_i,
	input wire halt_i,
	input wire tsc_pkg::word_t i_data_i,
	output logic i_read_o,
	output tsc_pkg::word_t i_address_o,
	output tsc_pkg::word_t instr_o,
	output tsc_pkg::word_t pc_o,
	output logic valid_o
);

	tsc_pkg::word_t pc;
	logic running;

	// no request in the first cycle out of reset
	assign i_read_o = running && !halt_i;
	assign i_address_o = pc;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pc <= RESET_PC;
			running <= 1'b0;
			valid_o <= 1'b0;
		end else begin
			running <= 1'b1;
			if (redirect_i) begin
				pc <= redirect_pc_i;
				// drop the word fetched behind the jump
				valid_o <= 1'b0;
			end else if (!stall_i) begin
				if (i_read_o)
					pc <= pc + 16'd1;
				valid_o <= i_read_o;
			end
		end
	end

	// IF/ID payload
	always_ff @(posedge clk) begin
		if (!stall_i) begin
			instr_o <= i_data_i;
			pc_o <= pc;
		end
	end

	a_stall_holds_pc: assert property (@(posedge clk) disable iff (!reset_n)
		stall_i |=> $stable(pc));

endmodule

`default_nettype wire

//--- verilog/memory_stage.sv
`timescale 1ns/1ns
`default_nettype none

module memory_stage (
	input wire clk,
	input wire reset_n,
	input wire tsc_pkg::word_t result_i,
	input wire tsc_pkg::word_t store_data_i,
	input wire tsc_pkg::reg_addr_t dest_i,
	input wire mem_read_i,
	input wire mem_write_i,
	input wire reg_write_i,
	input wire wwd_i,
	input wire halt_i,
	input wire valid_i,
	input wire tsc_pkg::word_t d_rdata_i,
	output logic d_read_o,
	output logic d_write_o,
	output tsc_pkg::word_t d_address_o,
	output tsc_pkg::word_t d_wdata_o,
	output tsc_pkg::word_t data_o,
	output tsc_pkg::reg_addr_t dest_o,
	output logic reg_write_o,
	output logic wwd_o,
	output logic halt_o,
	output logic valid_o
);

	assign d_read_o = valid_i && mem_read_i;
	assign d_write_o = valid_i && mem_write_i;
	assign d_address_o = result_i;
	assign d_wdata_o = store_data_i;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			reg_write_o <= 1'b0;
			wwd_o <= 1'b0;
			halt_o <= 1'b0;
			valid_o <= 1'b0;
		end else begin
			reg_write_o <= valid_i && reg_write_i;
			wwd_o <= valid_i && wwd_i;
			halt_o <= valid_i && halt_i;
			valid_o <= valid_i;
		end
	end

	always_ff @(posedge clk) begin
		data_o <= d_read_o ? d_rdata_i : result_i;
		dest_o <= dest_i;
	end

endmodule

`default_nettype wire

//--- verilog/register_file.sv
`timescale 1ns/1ns
`default_nettype none

module register_file (
	input wire clk,
	input wire reset_n,
	input wire tsc_pkg::reg_addr_t rs_i,
	input wire tsc_pkg::reg_addr_t rt_i,
	output tsc_pkg::word_t rs_data_o,
	output tsc_pkg::word_t rt_data_o,
	input wire we_i,
	input wire tsc_pkg::reg_addr_t wr_addr_i,
	input wire tsc_pkg::word_t wr_data_i
);

	tsc_pkg::word_t regs [4];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < 4; i++)
				regs[i] <= '0;
		end else if (we_i) begin
			regs[wr_addr_i] <= wr_data_i;
		end
	end

	// write-back data goes straight to a same-cycle read
	always_comb begin
		if (we_i && wr_addr_i == rs_i)
			rs_data_o = wr_data_i;
		else
			rs_data_o = regs[rs_i];
		if (we_i && wr_addr_i == rt_i)
			rt_data_o = wr_data_i;
		else
			rt_data_o = regs[rt_i];
	end

endmodule

`default_nettype wire

//--- verilog/tsc_cpu.sv
`timescale 1ns/1ns
`default_nettype none

module tsc_cpu #(
	parameter tsc_pkg::word_t RESET_PC = 16'h0000
) (
	input wire clk,
	input wire reset_n,
	output logic i_read_o,
	output tsc_pkg::word_t i_address_o,
	input wire tsc_pkg::word_t i_data_i,
	output logic d_read_o,
	output logic d_write_o,
	output tsc_pkg::word_t d_address_o,
	output tsc_pkg::word_t d_wdata_o,
	input wire tsc_pkg::word_t d_rdata_i,
	output tsc_pkg::word_t output_port_o,
	output logic out_strobe_o,
	output tsc_pkg::word_t num_inst_o,
	output logic is_halted_o
);

	// fetch/decode
	tsc_pkg::word_t if_instr, if_pc, redirect_pc;
	logic if_valid, stall, redirect, halt;
	// register file
	tsc_pkg::reg_addr_t rs, rt, rf_addr;
	tsc_pkg::word_t rs_data, rt_data, rf_data;
	logic rf_we;
	// decode/execute
	tsc_pkg::word_t id_a, id_b, id_imm;
	tsc_pkg::reg_addr_t id_src_a, id_src_b, id_dest;
	tsc_pkg::alu_op_t id_alu_op;
	logic id_use_imm, id_mem_read, id_mem_write, id_reg_write, id_wwd, id_halt, id_valid;
	// execute/memory
	tsc_pkg::word_t ex_result, ex_store_data;
	tsc_pkg::reg_addr_t ex_dest;
	logic ex_mem_read, ex_mem_write, ex_reg_write, ex_wwd, ex_halt, ex_valid;
	// memory/write-back
	tsc_pkg::word_t mem_data;
	tsc_pkg::reg_addr_t mem_dest;
	logic mem_reg_write, mem_wwd, mem_halt, mem_valid;

	fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
		.clk, .reset_n, .stall_i(stall), .redirect_i(redirect),
		.redirect_pc_i(redirect_pc), .halt_i(halt), .i_data_i,
		.i_read_o, .i_address_o, .instr_o(if_instr), .pc_o(if_pc), .valid_o(if_valid)
	);

	register_file u_regs (
		.clk, .reset_n, .rs_i(rs), .rt_i(rt), .rs_data_o(rs_data), .rt_data_o(rt_data),
		.we_i(rf_we), .wr_addr_i(rf_addr), .wr_data_i(rf_data)
	);

	decode_stage u_decode (
		.clk, .reset_n, .instr_i(if_instr), .pc_i(if_pc), .valid_i(if_valid),
		.rs_data_i(rs_data), .rt_data_i(rt_data), .rs_o(rs), .rt_o(rt),
		.stall_o(stall), .redirect_o(redirect), .redirect_pc_o(redirect_pc), .halt_o(halt),
		.a_o(id_a), .b_o(id_b), .src_a_o(id_src_a), .src_b_o(id_src_b), .dest_o(id_dest),
		.imm_o(id_imm), .alu_op_o(id_alu_op), .use_imm_o(id_use_imm),
		.mem_read_o(id_mem_read), .mem_write_o(id_mem_write), .reg_write_o(id_reg_write),
		.wwd_o(id_wwd), .halt_flag_o(id_halt), .valid_o(id_valid)
	);

	// a load never sits in memory while its consumer is in execute,
	// so the registered ALU result is the memory-stage forward value
	execute_stage u_execute (
		.clk, .reset_n, .a_i(id_a), .b_i(id_b), .src_a_i(id_src_a), .src_b_i(id_src_b),
		.dest_i(id_dest), .imm_i(id_imm), .alu_op_i(id_alu_op), .use_imm_i(id_use_imm),
		.mem_read_i(id_mem_read), .mem_write_i(id_mem_write), .reg_write_i(id_reg_write),
		.wwd_i(id_wwd), .halt_flag_i(id_halt), .valid_i(id_valid),
		.mem_dest_i(ex_dest), .mem_result_i(ex_result), .mem_reg_write_i(ex_reg_write),
		.wb_dest_i(rf_addr), .wb_data_i(rf_data), .wb_reg_write_i(rf_we),
		.result_o(ex_result), .store_data_o(ex_store_data), .dest_o(ex_dest),
		.mem_read_o(ex_mem_read), .mem_write_o(ex_mem_write), .reg_write_o(ex_reg_write),
		.wwd_o(ex_wwd), .halt_o(ex_halt), .valid_o(ex_valid)
	);

	memory_stage u_memory (
		.clk, .reset_n, .result_i(ex_result), .store_data_i(ex_store_data),
		.dest_i(ex_dest), .mem_read_i(ex_mem_read), .mem_write_i(ex_mem_write),
		.reg_write_i(ex_reg_write), .wwd_i(ex_wwd), .halt_i(ex_halt), .valid_i(ex_valid),
		.d_rdata_i, .d_read_o, .d_write_o, .d_address_o, .d_wdata_o,
		.data_o(mem_data), .dest_o(mem_dest), .reg_write_o(mem_reg_write),
		.wwd_o(mem_wwd), .halt_o(mem_halt), .valid_o(mem_valid)
	);

	writeback_stage u_writeback (
		.clk, .reset_n, .data_i(mem_data), .dest_i(mem_dest), .reg_write_i(mem_reg_write),
		.wwd_i(mem_wwd), .halt_i(mem_halt), .valid_i(mem_valid),
		.rf_we_o(rf_we), .rf_addr_o(rf_addr), .rf_data_o(rf_data),
		.output_port_o, .out_strobe_o, .num_inst_o, .is_halted_o
	);

endmodule

`default_nettype wire

//--- verilog/tsc_pkg.sv
`default_nettype none

package tsc_pkg;

	typedef logic [15:0] word_t;
	typedef logic [1:0] reg_addr_t;
	typedef logic [3:0] opcode_t;
	typedef logic [5:0] funct_t;

	// major opcodes in bits 15..12
	localparam opcode_t OP_ADI = 4'd4;
	localparam opcode_t OP_ORI = 4'd5;
	localparam opcode_t OP_LHI = 4'd6;
	localparam opcode_t OP_LWD = 4'd7;
	localparam opcode_t OP_SWD = 4'd8;
	localparam opcode_t OP_JMP = 4'd9;
	localparam opcode_t OP_RTYPE = 4'd15;

	// R-type function codes in bits 5..0
	localparam funct_t FN_ADD = 6'd0;
	localparam funct_t FN_SUB = 6'd1;
	localparam funct_t FN_AND = 6'd2;
	localparam funct_t FN_ORR = 6'd3;
	localparam funct_t FN_NOT = 6'd4;
	localparam funct_t FN_TCP = 6'd5;
	localparam funct_t FN_SHL = 6'd6;
	localparam funct_t FN_SHR = 6'd7;
	localparam funct_t FN_WWD = 6'd28;
	localparam funct_t FN_HLT = 6'd29;

	// first eight follow the function code order
	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
		ALU_NOT, ALU_TCP, ALU_SHL, ALU_SHR,
		ALU_PASS_B
	} alu_op_t;

	typedef enum logic [1:0] {
		FWD_REG, FWD_MEM, FWD_WB
	} fwd_sel_t;

endpackage

`default_nettype wire

//--- verilog/writeback_stage.sv
`timescale 1ns/1ns
`default_nettype none

module writeback_stage (
	input wire clk,
	input wire reset_n,
	input wire tsc_pkg::word_t data_i,
	input wire tsc_pkg::reg_addr_t dest_i,
	input wire reg_write_i,
	input wire wwd_i,
	input wire halt_i,
	input wire valid_i,
	output logic rf_we_o,
	output tsc_pkg::reg_addr_t rf_addr_o,
	output tsc_pkg::word_t rf_data_o,
	output tsc_pkg::word_t output_port_o,
	output logic out_strobe_o,
	output tsc_pkg::word_t num_inst_o,
	output logic is_halted_o
);

	assign rf_we_o = valid_i && reg_write_i;
	assign rf_addr_o = dest_i;
	assign rf_data_o = data_i;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			output_port_o <= '0;
			out_strobe_o <= 1'b0;
			num_inst_o <= '0;
			is_halted_o <= 1'b0;
		end else begin
			out_strobe_o <= valid_i && wwd_i;
			if (valid_i && wwd_i)
				output_port_o <= data_i;
			// jumps and halt count too
			if (valid_i)
				num_inst_o <= num_inst_o + 16'd1;
			if (valid_i && halt_i)
				is_halted_o <= 1'b1;
		end
	end

	// nothing follows the halt down the pipeline
	a_idle_after_halt: assert property (@(posedge clk) disable iff (!reset_n)
		is_halted_o |-> !valid_i);

endmodule

`default_nettype wire
